// File: design/vec_issue_pkg.sv
`default_nettype none

package vec_issue_pkg;

   localparam int NUM_LANES   = 4;
   localparam int LANE_W      = 2;                // Lane index width
   localparam int R_PORTS_NUM = 2 * NUM_LANES;
   localparam int W_PORTS_NUM = NUM_LANES;
   localparam int NUM_VREGS   = 32;
   localparam int VREG_AW     = 5;
   localparam int ELEM_W      = 8;
   localparam int ELEMS       = 4;
   localparam int XLEN        = ELEM_W * ELEMS;
   localparam int INSTR_W     = 32;

   localparam logic [3:0] OPC_VV   = 4'd0;
   localparam logic [3:0] OPC_VI   = 4'd1;
   localparam logic [1:0] FUNC_BAD = 2'd3;     // Reserved func in both formats

   // Lane sequencer states
   localparam int         ST_W    = 3;
   localparam logic [2:0] ST_IDLE = 3'd0;
   localparam logic [2:0] ST_RD_A = 3'd1;
   localparam logic [2:0] ST_WT_A = 3'd2;
   localparam logic [2:0] ST_RD_B = 3'd3;
   localparam logic [2:0] ST_WT_B = 3'd4;
   localparam logic [2:0] ST_COMP = 3'd5;
   localparam logic [2:0] ST_WR   = 3'd6;

   typedef enum logic [1:0] {CLS_VV, CLS_VI, CLS_ILLEGAL} instr_class_e;
   typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_XOR} vop_e;

   typedef struct packed {
      logic [3:0]         opcode;
      logic [1:0]         func;
      logic [VREG_AW-1:0] vd;
      logic [VREG_AW-1:0] vs1;
      logic [VREG_AW-1:0] vs2;
      logic [10:0]        rsvd;
   } instr_vv_t;

   typedef struct packed {
      logic [3:0]         opcode;
      logic [1:0]         func;
      logic [VREG_AW-1:0] vd;
      logic [VREG_AW-1:0] vs1;
      logic [ELEM_W-1:0]  imm;
      logic [7:0]         rsvd;
   } instr_vi_t;

   // Same word seen as either format, the opcode picks which one is meant
   typedef union packed {
      instr_vv_t vv;
      instr_vi_t vi;
   } instr_u;

   typedef struct packed {
      vop_e               op;
      instr_class_e       cls;
      logic [VREG_AW-1:0] vd;
      logic [VREG_AW-1:0] vs1;
      logic [VREG_AW-1:0] vs2;
      logic [ELEM_W-1:0]  imm;
   } lane_op_t;

endpackage

`default_nettype wire

// File: design/vrf_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// One lane's path to the register file arbiter
interface vrf_bus_if import vec_issue_pkg::*; ();

   logic               req;
   logic               we;
   logic [VREG_AW-1:0] addr;
   logic [XLEN-1:0]    wdata;
   logic               gnt;
   logic [XLEN-1:0]    rdata;   // Valid the cycle after a read grant

   modport lane (
      output req, we, addr, wdata,
      input  gnt, rdata
   );

   modport arb (
      input  req, we, addr, wdata,
      output gnt, rdata
   );

endinterface

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder import vec_issue_pkg::*; (
   input  wire instr_u       instr_i,
   output instr_class_e      cls_o,
   output lane_op_t          op_o,
   output logic [2:0]        reg_mask_o   // {vs2, vs1, vd}
);

   logic is_vv;
   logic is_vi;
   logic func_ok;

   // Opcode and func sit at the same place in both views
   assign func_ok = instr_i.vv.func != FUNC_BAD;
   assign is_vv   = func_ok && (instr_i.vv.opcode == OPC_VV);
   assign is_vi   = func_ok && (instr_i.vi.opcode == OPC_VI);

   always_comb
   begin
      cls_o      = CLS_ILLEGAL;
      reg_mask_o = 3'b000;
      op_o       = '0;
      op_o.vd    = instr_i.vv.vd;
      op_o.vs1   = instr_i.vv.vs1;

      if (is_vv)
      begin
         cls_o      = CLS_VV;
         reg_mask_o = 3'b111;
         op_o.vs2   = instr_i.vv.vs2;
      end
      else if (is_vi)
      begin
         cls_o      = CLS_VI;
         reg_mask_o = 3'b011;              // No second source register
         op_o.imm   = instr_i.vi.imm;
      end

      op_o.cls = cls_o;
      if (cls_o != CLS_ILLEGAL)
      begin
         op_o.op = vop_e'(instr_i.vv.func);
      end
      else
      begin
         op_o.op = OP_ADD;                 // Never reaches a lane
      end
   end

endmodule

`default_nettype wire

// File: design/resource_allocate_unit.sv
`timescale 1ns/10ps
`default_nettype none

module resource_allocate_unit import vec_issue_pkg::*; (
   input  wire                      clk,
   input  wire                      rstn,
   input  wire                      instr_vld_i,
   input  wire instr_class_e        cls_i,
   input  wire lane_op_t            op_i,
   input  wire [2:0]                reg_mask_i,
   output logic                     instr_rdy_o,
   output logic                     alloc_vld_o,
   output lane_op_t                 alloc_op_o,
   output logic [R_PORTS_NUM-1:0]   r_port_en_o,
   output logic [W_PORTS_NUM-1:0]   w_port_en_o,
   input  wire [NUM_LANES-1:0]      free_lane_i
);

   logic [NUM_LANES-1:0]                busy_q;
   logic [LANE_W-1:0]                   rr_ptr_q;
   logic [NUM_LANES-1:0][NUM_VREGS-1:0] pend_q;       // Registers held per lane

   logic                 legal;
   logic                 lane_found;
   logic [LANE_W-1:0]    sel_lane;
   logic [LANE_W-1:0]    idx;
   logic [NUM_VREGS-1:0] pend_all;
   logic [NUM_VREGS-1:0] use_vec;
   logic                 hazard;

   assign legal = cls_i != CLS_ILLEGAL;

   // First free lane at or after the pointer
   always_comb
   begin
      lane_found = 1'b0;
      sel_lane   = '0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         idx = rr_ptr_q + LANE_W'(i);
         if (!lane_found && !busy_q[idx])
         begin
            lane_found = 1'b1;
            sel_lane   = idx;
         end
      end
   end

   always_comb
   begin
      pend_all = '0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         pend_all = pend_all | pend_q[i];
      end

      use_vec = '0;
      if (reg_mask_i[0]) use_vec[op_i.vd]  = 1'b1;
      if (reg_mask_i[1]) use_vec[op_i.vs1] = 1'b1;
      if (reg_mask_i[2]) use_vec[op_i.vs2] = 1'b1;
   end

   assign hazard = |(use_vec & pend_all);

   // Illegal words are always taken and dropped
   assign instr_rdy_o = !legal || (lane_found && !hazard);
   assign alloc_vld_o = instr_vld_i && legal && lane_found && !hazard;
   assign alloc_op_o  = op_i;

   always_comb
   begin
      r_port_en_o = '0;
      w_port_en_o = '0;
      if (legal && lane_found)
      begin
         w_port_en_o[sel_lane]          = 1'b1;
         r_port_en_o[2*sel_lane + 1]    = 1'b1;              // vs1 port
         r_port_en_o[2*sel_lane]        = cls_i == CLS_VV;   // vs2 port
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         busy_q   <= '0;
         rr_ptr_q <= '0;
         pend_q   <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_LANES; i++)
         begin
            if (free_lane_i[i])
            begin
               busy_q[i] <= 1'b0;
               pend_q[i] <= '0;
            end
         end
         if (alloc_vld_o)
         begin
            busy_q[sel_lane] <= 1'b1;
            pend_q[sel_lane] <= use_vec;
            rr_ptr_q         <= sel_lane + 1'b1;
         end
      end
   end

   a_no_alloc_busy: assert property (@(posedge clk) disable iff (!rstn)
      alloc_vld_o |-> (w_port_en_o & busy_q) == '0);

   a_wport_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(w_port_en_o));

endmodule

`default_nettype wire

// File: design/vector_lane.sv
`timescale 1ns/10ps
`default_nettype none

module vector_lane import vec_issue_pkg::*; (
   input  wire                clk,
   input  wire                rstn,
   input  wire                alloc_vld_i,
   input  wire lane_op_t      alloc_op_i,
   input  wire [1:0]          r_port_en_i,   // [1] vs1 port, [0] vs2 port
   input  wire                w_port_en_i,
   vrf_bus_if.lane            bus,
   output logic               free_o,
   output logic               retire_vld_o,
   output logic [VREG_AW-1:0] retire_vd_o,
   output logic [XLEN-1:0]    retire_data_o
);

   logic [ST_W-1:0] state_q;
   logic            rd_b_q;       // Second source read needed
   logic            done_q;
   lane_op_t        op_q;
   logic [XLEN-1:0] opa_q;
   logic [XLEN-1:0] opb_q;
   logic [XLEN-1:0] result_q;
   logic [XLEN-1:0] opb;
   logic            take;

   // Element-wise with wraparound, no carry between elements
   function automatic logic [XLEN-1:0] simd_op(input vop_e op,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
      logic [XLEN-1:0] r;
      r = '0;
      for (int e = 0; e < ELEMS; e++)
      begin
         case (op)
            OP_ADD:  r[e*ELEM_W +: ELEM_W] = a[e*ELEM_W +: ELEM_W] + b[e*ELEM_W +: ELEM_W];
            OP_SUB:  r[e*ELEM_W +: ELEM_W] = a[e*ELEM_W +: ELEM_W] - b[e*ELEM_W +: ELEM_W];
            default: r[e*ELEM_W +: ELEM_W] = a[e*ELEM_W +: ELEM_W] ^ b[e*ELEM_W +: ELEM_W];
         endcase
      end
      return r;
   endfunction

   assign take = alloc_vld_i && w_port_en_i;
   assign opb  = (op_q.cls == CLS_VI) ? {ELEMS{op_q.imm}} : opb_q;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         state_q <= ST_IDLE;
         rd_b_q  <= 1'b0;
         done_q  <= 1'b0;
      end
      else
      begin
         done_q <= 1'b0;
         case (state_q)
            ST_IDLE:
               if (take)
               begin
                  rd_b_q  <= r_port_en_i[0];
                  state_q <= r_port_en_i[1] ? ST_RD_A : ST_COMP;
               end
            ST_RD_A: if (bus.gnt) state_q <= ST_WT_A;
            ST_WT_A: state_q <= rd_b_q ? ST_RD_B : ST_COMP;
            ST_RD_B: if (bus.gnt) state_q <= ST_WT_B;
            ST_WT_B: state_q <= ST_COMP;
            ST_COMP: state_q <= ST_WR;
            ST_WR:
               if (bus.gnt)
               begin
                  done_q  <= 1'b1;   // Write lands at this edge
                  state_q <= ST_IDLE;
               end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == ST_IDLE && take) op_q <= alloc_op_i;
      if (state_q == ST_WT_A) opa_q <= bus.rdata;
      if (state_q == ST_WT_B) opb_q <= bus.rdata;
      if (state_q == ST_COMP) result_q <= simd_op(op_q.op, opa_q, opb);
   end

   assign bus.req   = (state_q == ST_RD_A) || (state_q == ST_RD_B) || (state_q == ST_WR);
   assign bus.we    = state_q == ST_WR;
   assign bus.addr  = (state_q == ST_WR)   ? op_q.vd  :
                      (state_q == ST_RD_B) ? op_q.vs2 : op_q.vs1;
   assign bus.wdata = result_q;

   assign free_o        = done_q;
   assign retire_vld_o  = done_q;
   assign retire_vd_o   = op_q.vd;
   assign retire_data_o = result_q;

   // Request and its fields stay put until the arbiter answers
   a_req_held: assert property (@(posedge clk) disable iff (!rstn)
      bus.req && !bus.gnt |=> bus.req && $stable(bus.addr) && $stable(bus.we));

   a_take_idle: assert property (@(posedge clk) disable iff (!rstn)
      take |-> state_q == ST_IDLE);

endmodule

`default_nettype wire

// File: design/vrf_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module vrf_arbiter import vec_issue_pkg::*; (
   input  wire                clk,
   input  wire                rstn,
   vrf_bus_if.arb             lanes [NUM_LANES],
   output logic               bank_en_o,
   output logic               bank_we_o,
   output logic [VREG_AW-1:0] bank_addr_o,
   output logic [XLEN-1:0]    bank_wdata_o,
   input  wire [XLEN-1:0]     bank_rdata_i
);

   logic [NUM_LANES-1:0]               req_v;
   logic [NUM_LANES-1:0]               we_v;
   logic [NUM_LANES-1:0][VREG_AW-1:0]  addr_v;
   logic [NUM_LANES-1:0][XLEN-1:0]     wdata_v;
   logic [NUM_LANES-1:0]               gnt;
   logic [LANE_W-1:0]                  ptr_q;
   logic [LANE_W-1:0]                  gnt_idx;
   logic [LANE_W-1:0]                  idx;
   logic                               any_gnt;
   logic                               rd_vld_q;
   logic [LANE_W-1:0]                  rd_idx_q;   // Lane owed the read data

   for (genvar g = 0; g < NUM_LANES; g++)
   begin : g_lane
      assign req_v[g]       = lanes[g].req;
      assign we_v[g]        = lanes[g].we;
      assign addr_v[g]      = lanes[g].addr;
      assign wdata_v[g]     = lanes[g].wdata;
      assign lanes[g].gnt   = gnt[g];
      assign lanes[g].rdata = (rd_vld_q && rd_idx_q == LANE_W'(g)) ? bank_rdata_i : '0;
   end

   // Highest priority goes to the lane after the last winner
   always_comb
   begin
      any_gnt = 1'b0;
      gnt_idx = '0;
      gnt     = '0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         idx = ptr_q + LANE_W'(i);
         if (!any_gnt && req_v[idx])
         begin
            any_gnt      = 1'b1;
            gnt_idx      = idx;
            gnt[idx]     = 1'b1;
         end
      end
   end

   assign bank_en_o    = any_gnt;
   assign bank_we_o    = any_gnt && we_v[gnt_idx];
   assign bank_addr_o  = addr_v[gnt_idx];
   assign bank_wdata_o = wdata_v[gnt_idx];

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ptr_q    <= '0;
         rd_vld_q <= 1'b0;
         rd_idx_q <= '0;
      end
      else
      begin
         if (any_gnt) ptr_q <= gnt_idx + 1'b1;
         rd_vld_q <= any_gnt && !we_v[gnt_idx];
         rd_idx_q <= gnt_idx;
      end
   end

   a_gnt_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(gnt));

endmodule

`default_nettype wire

// File: design/vrf_bank.sv
`timescale 1ns/10ps
`default_nettype none

module vrf_bank import vec_issue_pkg::*; (
   input  wire                clk,
   input  wire                rstn,
   input  wire                en_i,
   input  wire                we_i,
   input  wire [VREG_AW-1:0]  addr_i,
   input  wire [XLEN-1:0]     wdata_i,
   output logic [XLEN-1:0]    rdata_o
);

   logic [NUM_VREGS-1:0][XLEN-1:0] mem_q;

   // Architectural registers start at zero
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         mem_q <= '0;
      end
      else if (en_i && we_i)
      begin
         mem_q[addr_i] <= wdata_i;
      end
   end

   // One cycle read latency
   always_ff @(posedge clk)
   begin
      if (en_i && !we_i) rdata_o <= mem_q[addr_i];
   end

endmodule

`default_nettype wire

// File: design/vec_issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module vec_issue_top import vec_issue_pkg::*; (
   input  wire                clk,
   input  wire                rstn,
   input  wire                instr_vld_i,
   input  wire [INSTR_W-1:0]  instr_i,
   output logic               instr_rdy_o,
   output logic               retire_vld_o,
   output logic [VREG_AW-1:0] retire_vd_o,
   output logic [XLEN-1:0]    retire_data_o
);

   instr_class_e                      cls;
   lane_op_t                          dec_op;
   logic [2:0]                        reg_mask;
   logic                              alloc_vld;
   lane_op_t                          alloc_op;
   logic [R_PORTS_NUM-1:0]            r_port_en;
   logic [W_PORTS_NUM-1:0]            w_port_en;
   logic [NUM_LANES-1:0]              lane_free;
   logic [NUM_LANES-1:0]              lane_ret;
   logic [NUM_LANES-1:0][VREG_AW-1:0] lane_vd;
   logic [NUM_LANES-1:0][XLEN-1:0]    lane_data;
   logic                              bank_en;
   logic                              bank_we;
   logic [VREG_AW-1:0]                bank_addr;
   logic [XLEN-1:0]                   bank_wdata;
   logic [XLEN-1:0]                   bank_rdata;

   vrf_bus_if bus [NUM_LANES] ();

   instr_decoder u_dec (
      .instr_i    (instr_i),
      .cls_o      (cls),
      .op_o       (dec_op),
      .reg_mask_o (reg_mask)
   );

   resource_allocate_unit u_alloc (
      .clk         (clk),
      .rstn        (rstn),
      .instr_vld_i (instr_vld_i),
      .cls_i       (cls),
      .op_i        (dec_op),
      .reg_mask_i  (reg_mask),
      .instr_rdy_o (instr_rdy_o),
      .alloc_vld_o (alloc_vld),
      .alloc_op_o  (alloc_op),
      .r_port_en_o (r_port_en),
      .w_port_en_o (w_port_en),
      .free_lane_i (lane_free)
   );

   for (genvar g = 0; g < NUM_LANES; g++)
   begin : g_lane
      vector_lane u_lane (
         .clk           (clk),
         .rstn          (rstn),
         .alloc_vld_i   (alloc_vld),
         .alloc_op_i    (alloc_op),
         .r_port_en_i   (r_port_en[2*g+1 -: 2]),
         .w_port_en_i   (w_port_en[g]),
         .bus           (bus[g]),
         .free_o        (lane_free[g]),
         .retire_vld_o  (lane_ret[g]),
         .retire_vd_o   (lane_vd[g]),
         .retire_data_o (lane_data[g])
      );
   end

   vrf_arbiter u_arb (
      .clk          (clk),
      .rstn         (rstn),
      .lanes        (bus),
      .bank_en_o    (bank_en),
      .bank_we_o    (bank_we),
      .bank_addr_o  (bank_addr),
      .bank_wdata_o (bank_wdata),
      .bank_rdata_i (bank_rdata)
   );

   vrf_bank u_bank (
      .clk     (clk),
      .rstn    (rstn),
      .en_i    (bank_en),
      .we_i    (bank_we),
      .addr_i  (bank_addr),
      .wdata_i (bank_wdata),
      .rdata_o (bank_rdata)
   );

   // Only one write is granted per cycle, so at most one lane retires
   always_comb
   begin
      retire_vld_o  = |lane_ret;
      retire_vd_o   = '0;
      retire_data_o = '0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         retire_vd_o   = retire_vd_o   | (lane_vd[i]   & {VREG_AW{lane_ret[i]}});
         retire_data_o = retire_data_o | (lane_data[i] & {XLEN{lane_ret[i]}});
      end
   end

endmodule

`default_nettype wire

// File: dv/tb_vec_issue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vec_issue import vec_issue_pkg::*; ();

   localparam int N_SEED         = NUM_VREGS;
   localparam int N_MIX          = 640;
   localparam int N_GROUPS       = 20;        // Five instructions per group
   localparam int N_READ         = NUM_VREGS;
   localparam int N_TOTAL        = N_SEED + N_MIX + 5 * N_GROUPS + N_READ;
   localparam int TIMEOUT_CYCLES = 40 * N_TOTAL;

   logic               clk;
   logic               rstn;
   logic               instr_vld_i;
   logic [INSTR_W-1:0] instr_i;
   logic               instr_rdy_o;
   logic               retire_vld_o;
   logic [VREG_AW-1:0] retire_vd_o;
   logic [XLEN-1:0]    retire_data_o;

   // Reference model, indexed by destination register
   logic [XLEN-1:0]      model_reg   [NUM_VREGS];
   logic [XLEN-1:0]      exp_data    [NUM_VREGS];
   logic [NUM_VREGS-1:0] exp_use     [NUM_VREGS];   // Registers named by the in-flight op
   bit                   in_flight   [NUM_VREGS];
   bit                   release_due [NUM_VREGS];   // Retired, lane frees at next edge
   int                   n_busy      = 0;
   int                   cycles      = 0;

   // Instruction currently on the input
   bit                   cur_legal;
   bit                   cur_vv;
   logic [1:0]           cur_func;
   logic [VREG_AW-1:0]   cur_vd;
   logic [VREG_AW-1:0]   cur_vs1;
   logic [VREG_AW-1:0]   cur_vs2;
   logic [ELEM_W-1:0]    cur_imm;
   bit                   accepted;

   vec_issue_top u_dut (
      .clk           (clk),
      .rstn          (rstn),
      .instr_vld_i   (instr_vld_i),
      .instr_i       (instr_i),
      .instr_rdy_o   (instr_rdy_o),
      .retire_vld_o  (retire_vld_o),
      .retire_vd_o   (retire_vd_o),
      .retire_data_o (retire_data_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_run();
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at cycle %0d", cycles);
   endtask

   task automatic fail_plain(input string why);
      $display("ERROR: %s", why);
      stop_run();
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("ERROR: timeout after %0d cycles, the DUT stopped making progress", cycles);
         stop_run();
      end
   end

   // Four 8-bit elements, each wrapping on its own
   function automatic logic [XLEN-1:0] lane_math(input logic [1:0] func,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
      logic [7:0]      x;
      logic [7:0]      y;
      logic [7:0]      z;
      logic [XLEN-1:0] r;
      r = '0;
      for (int e = 0; e < ELEMS; e++)
      begin
         x = a[8*e +: 8];
         y = b[8*e +: 8];
         if (func == 2'd0) z = x + y;
         else if (func == 2'd1) z = x - y;
         else z = x ^ y;
         r[8*e +: 8] = z;
      end
      return r;
   endfunction

   function automatic logic [NUM_VREGS-1:0] pending_regs();
      logic [NUM_VREGS-1:0] p;
      p = '0;
      for (int r = 0; r < NUM_VREGS; r++)
      begin
         if (in_flight[r]) p = p | exp_use[r];
      end
      return p;
   endfunction

   function automatic logic [VREG_AW-1:0] pick_reg();
      logic [31:0] r;
      r = $urandom;
      return r[VREG_AW-1:0];
   endfunction

   function automatic logic [1:0] pick_func();
      logic [31:0] r;
      r = $urandom % 3;
      return r[1:0];
   endfunction

   function automatic logic [ELEM_W-1:0] pick_byte();
      logic [31:0] r;
      r = $urandom;
      return r[ELEM_W-1:0];
   endfunction

   // Runs at the falling edge, where all DUT outputs are settled
   task automatic cycle_step();
      logic [NUM_VREGS-1:0] use_set;
      logic                 exp_rdy;
      logic [XLEN-1:0]      a;
      logic [XLEN-1:0]      b;
      for (int r = 0; r < NUM_VREGS; r++)
      begin
         if (release_due[r])
         begin
            release_due[r] = 1'b0;
            in_flight[r]   = 1'b0;
            n_busy--;
         end
      end
      if (instr_vld_i)
      begin
         use_set = '0;
         if (cur_legal)
         begin
            use_set[cur_vd]  = 1'b1;
            use_set[cur_vs1] = 1'b1;
            if (cur_vv) use_set[cur_vs2] = 1'b1;
         end
         exp_rdy = !cur_legal || (n_busy < NUM_LANES && (use_set & pending_regs()) == '0);
         check_val("instr_rdy_o", 32'(instr_rdy_o), 32'(exp_rdy));
         if (instr_rdy_o)
         begin
            accepted = 1'b1;
            if (cur_legal)
            begin
               a                 = model_reg[cur_vs1];
               b                 = cur_vv ? model_reg[cur_vs2] : {ELEMS{cur_imm}};
               exp_data[cur_vd]  = lane_math(cur_func, a, b);
               exp_use[cur_vd]   = use_set;
               model_reg[cur_vd] = exp_data[cur_vd];
               in_flight[cur_vd] = 1'b1;
               n_busy++;
            end
         end
      end
      if (retire_vld_o)
      begin
         if (!in_flight[retire_vd_o] || release_due[retire_vd_o])
            fail_plain("a retire came for a register with no instruction in flight");
         check_val("retire_data_o", retire_data_o, exp_data[retire_vd_o]);
         release_due[retire_vd_o] = 1'b1;
      end
   endtask

   // Present one word and hold it until it is taken
   task automatic send(input logic [3:0] opc, input logic [1:0] func,
                       input logic [VREG_AW-1:0] vd, input logic [VREG_AW-1:0] vs1,
                       input logic [VREG_AW-1:0] vs2, input logic [ELEM_W-1:0] imm);
      logic [INSTR_W-1:0] word;
      if (opc == 4'd1) word = {opc, func, vd, vs1, imm, 8'h00};
      else word = {opc, func, vd, vs1, vs2, 11'h000};
      cur_legal = (opc == 4'd0 || opc == 4'd1) && func != 2'd3;
      cur_vv    = cur_legal && opc == 4'd0;
      cur_func  = func;
      cur_vd    = vd;
      cur_vs1   = vs1;
      cur_vs2   = vs2;
      cur_imm   = imm;
      accepted  = 1'b0;
      @(posedge clk);
      instr_vld_i <= 1'b1;
      instr_i     <= word;
      while (!accepted)
      begin
         @(negedge clk);
         cycle_step();
      end
   endtask

   task automatic idle(input int n);
      @(posedge clk);
      instr_vld_i <= 1'b0;
      repeat (n)
      begin
         @(negedge clk);
         cycle_step();
      end
   endtask

   task automatic drain();
      @(posedge clk);
      instr_vld_i <= 1'b0;
      do
      begin
         @(negedge clk);
         cycle_step();
      end while (n_busy != 0);
      check_val("instr_rdy_o", 32'(instr_rdy_o), 32'd1);   // Every lane and register released
   endtask

   // Five VV ops on 15 distinct registers, the fifth waits for a lane
   task automatic disjoint_group();
      logic [VREG_AW-1:0] base;
      base = pick_reg();
      drain();
      for (int i = 0; i < 5; i++)
      begin
         send(4'd0, pick_func(), base + VREG_AW'(3*i), base + VREG_AW'(3*i + 1),
              base + VREG_AW'(3*i + 2), 8'h00);
      end
   endtask

   initial
   begin
      int          kind;
      logic [31:0] r;
      void'($urandom(37));
      rstn        = 1'b0;
      instr_vld_i = 1'b0;
      instr_i     = '0;
      for (int i = 0; i < NUM_VREGS; i++)
      begin
         model_reg[i]   = '0;
         exp_data[i]    = '0;
         exp_use[i]     = '0;
         in_flight[i]   = 1'b0;
         release_due[i] = 1'b0;
      end
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      check_val("instr_rdy_o", 32'(instr_rdy_o), 32'd1);
      check_val("retire_vld_o", 32'(retire_vld_o), 32'd0);
      idle(3);

      for (int i = 0; i < N_SEED; i++)       // Seed every register
      begin
         send(4'd1, pick_func(), VREG_AW'(i), pick_reg(), 5'd0, pick_byte());
      end

      for (int i = 0; i < N_MIX; i++)
      begin
         kind = $urandom % 10;
         if (kind == 0)
         begin
            r = $urandom % 14;
            send(r[3:0] + 4'd2, pick_func(), pick_reg(), pick_reg(), pick_reg(), pick_byte());
         end
         else if (kind == 1)
            send(4'($urandom % 2), 2'd3, pick_reg(), pick_reg(), pick_reg(), pick_byte());
         else if (kind < 4)
            send(4'd1, pick_func(), pick_reg(), pick_reg(), 5'd0, pick_byte());
         else
            send(4'd0, pick_func(), pick_reg(), pick_reg(), pick_reg(), 8'h00);
         if ($urandom % 4 == 0) idle(1 + $urandom % 3);
      end

      for (int g = 0; g < N_GROUPS; g++) disjoint_group();

      drain();
      for (int i = 0; i < N_READ; i++)       // Read back through an add of zero
      begin
         send(4'd1, 2'd0, VREG_AW'(i), VREG_AW'(i), 5'd0, 8'h00);
      end
      drain();
      idle(8);                               // No stray retire after the last one
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
design/vec_issue_pkg.sv
design/vrf_bus_if.sv
design/instr_decoder.sv
design/resource_allocate_unit.sv
design/vector_lane.sv
design/vrf_arbiter.sv
design/vrf_bank.sv
design/vec_issue_top.sv
dv/tb_vec_issue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, exit status follows the run
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_vec_issue -f sim.f -o sim_vec_issue \
   && ./obj_dir/sim_vec_issue \
   || exit 1
